// ==== list.f ====
+incdir+tests
source/simd_data_pkg.sv
source/alu_op_pkg.sv
source/alu_op_decode.sv
source/simd_addsub_shift.sv
source/simd_mult.sv
source/simd_logic_rotate.sv
source/alu_result_stage.sv
source/vector_alu.sv
tests/vector_alu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run with Verilator, the log decides pass or fail
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert -Wno-fatal -f list.f --top-module vector_alu_tb \
	-o vector_alu_sim && ./obj_dir/vector_alu_sim; } > sim.log 2>&1 \
	|| echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// ==== source/alu_op_decode.sv ====
`timescale 1ns/1ps

module alu_op_decode
	import alu_op_pkg::*;
(
	input  r_ins_e    r_ins,
	input  width_e    ww,
	input  logic      op_en,
	output unit_e     unit_sel,
	output logic_op_e logic_op,
	output arith_op_e arith_op,
	output logic      mult_odd,
	output logic      mult_square
);

	always_comb begin
		unit_sel    = UNIT_NONE;
		logic_op    = LOP_AND;
		arith_op    = AOP_ADD;
		mult_odd    = (r_ins == VMULOU) || (r_ins == VSQOU);
		mult_square = (r_ins == VSQEU) || (r_ins == VSQOU);

		// Unit choice, anything not listed stays at zero result
		if (op_en) begin
			case (r_ins)
				VAND, VOR, VXOR, VNOT, VMOV, VRTTH: unit_sel = UNIT_LOGIC;
				VADD, VSUB, VSLL, VSRL, VSRA: unit_sel = UNIT_ARITH;
				VMULEU, VMULOU, VSQEU, VSQOU: begin
					// No 64x64 multiplier
					if (ww != WIDTH_64) begin
						unit_sel = UNIT_MULT;
					end
				end
				default: unit_sel = UNIT_NONE;
			endcase
		end

		case (r_ins)
			VOR:     logic_op = LOP_OR;
			VXOR:    logic_op = LOP_XOR;
			VNOT:    logic_op = LOP_NOT;
			VMOV:    logic_op = LOP_MOV;
			VRTTH:   logic_op = LOP_RTTH;
			default: logic_op = LOP_AND;
		endcase

		case (r_ins)
			VSUB:    arith_op = AOP_SUB;
			VSLL:    arith_op = AOP_SLL;
			VSRL:    arith_op = AOP_SRL;
			VSRA:    arith_op = AOP_SRA;
			default: arith_op = AOP_ADD;
		endcase
	end

endmodule

// ==== source/alu_op_pkg.sv ====
package alu_op_pkg;

	// R-type function codes, dropped ones kept so they decode as illegal
	typedef enum logic [5:0] {
		VNOP   = 6'd0,
		VAND   = 6'd1,
		VOR    = 6'd2,
		VXOR   = 6'd3,
		VNOT   = 6'd4,
		VMOV   = 6'd5,
		VADD   = 6'd6,
		VSUB   = 6'd7,
		VMULEU = 6'd8,
		VMULOU = 6'd9,
		VSLL   = 6'd10,
		VSRL   = 6'd11,
		VSRA   = 6'd12,
		VRTTH  = 6'd13,
		VDIV   = 6'd14,
		VMOD   = 6'd15,
		VSQEU  = 6'd16,
		VSQOU  = 6'd17,
		VSQRT  = 6'd18
	} r_ins_e;

	typedef enum logic [1:0] {
		WIDTH_8  = 2'd0,
		WIDTH_16 = 2'd1,
		WIDTH_32 = 2'd2,
		WIDTH_64 = 2'd3
	} width_e;

	typedef enum logic [1:0] {UNIT_NONE, UNIT_LOGIC, UNIT_ARITH, UNIT_MULT} unit_e;

	typedef enum logic [2:0] {LOP_AND, LOP_OR, LOP_XOR, LOP_NOT, LOP_MOV, LOP_RTTH} logic_op_e;

	typedef enum logic [2:0] {AOP_ADD, AOP_SUB, AOP_SLL, AOP_SRL, AOP_SRA} arith_op_e;

endpackage

// ==== source/alu_result_stage.sv ====
`timescale 1ns/1ps

module alu_result_stage
	import simd_data_pkg::*;
	import alu_op_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  unit_e  unit_sel,
	input  width_e ww,
	input  word_t  logic_word,
	input  word_t  arith_w8,
	input  word_t  arith_w16,
	input  word_t  arith_w32,
	input  word_t  arith_w64,
	input  word_t  mult_w8,
	input  word_t  mult_w16,
	input  word_t  mult_w32,
	output word_t  alu_out
);

	word_t next_out;

	always_comb begin
		next_out = '0;
		case (unit_sel)
			UNIT_LOGIC: next_out = logic_word;
			UNIT_ARITH: begin
				case (ww)
					WIDTH_8:  next_out = arith_w8;
					WIDTH_16: next_out = arith_w16;
					WIDTH_32: next_out = arith_w32;
					default:  next_out = arith_w64;
				endcase
			end
			UNIT_MULT: begin
				case (ww)
					WIDTH_8:  next_out = mult_w8;
					WIDTH_16: next_out = mult_w16;
					WIDTH_32: next_out = mult_w32;
					default:  next_out = '0;
				endcase
			end
			default: next_out = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			alu_out <= '0;
		end else begin
			alu_out <= next_out;
		end
	end

	// Decode never hands over a multiply at 64-bit lanes
	a_no_wide_mult: assert property (@(posedge clk) disable iff (reset)
		!(unit_sel == UNIT_MULT && ww == WIDTH_64))
		else $error("multiply unit selected at 64-bit width");

endmodule

// ==== source/simd_addsub_shift.sv ====
`timescale 1ns/1ps

module simd_addsub_shift
	import simd_data_pkg::*;
	import alu_op_pkg::*;
#(
	parameter int LANE_W = LANE_W8
) (
	input  word_t     ra,
	input  word_t     rb,
	input  arith_op_e arith_op,
	output word_t     result
);

	localparam int LANES = WORD_W / LANE_W;
	// Shift amount comes from the low bits of each rb lane
	localparam int SH_W  = (LANE_W > 1) ? $clog2(LANE_W) : 1;

	for (genvar i = 0; i < LANES; i++) begin : g_lane
		logic [LANE_W-1:0] a;
		logic [LANE_W-1:0] b;
		logic [SH_W-1:0]   amt;
		logic [LANE_W-1:0] y;

		// Lane i starts at bit i*LANE_W, its MSB
		assign a   = ra[i*LANE_W +: LANE_W];
		assign b   = rb[i*LANE_W +: LANE_W];
		assign amt = b[SH_W-1:0];

		always_comb begin
			case (arith_op)
				AOP_ADD: y = a + b;
				AOP_SUB: y = a - b;
				AOP_SLL: y = a << amt;
				AOP_SRL: y = a >> amt;
				// Fill with the lane's sign bit
				AOP_SRA: y = $signed(a) >>> amt;
				default: y = '0;
			endcase
		end

		assign result[i*LANE_W +: LANE_W] = y;
	end

endmodule

// ==== source/simd_data_pkg.sv ====
package simd_data_pkg;

	// Datapath word, bit 0 is the most significant
	localparam int WORD_W = 64;

	typedef logic [0:WORD_W-1] word_t;

	// Supported lane widths
	localparam int LANE_W8  = 8;
	localparam int LANE_W16 = 16;
	localparam int LANE_W32 = 32;
	localparam int LANE_W64 = 64;

	// Widest lane the multiplier takes, product is twice this
	localparam int MULT_MAX_W = 32;

endpackage

// ==== source/simd_logic_rotate.sv ====
`timescale 1ns/1ps

module simd_logic_rotate
	import simd_data_pkg::*;
	import alu_op_pkg::*;
(
	input  word_t     ra,
	input  word_t     rb,
	input  logic_op_e logic_op,
	input  width_e    ww,
	output word_t     result
);

	// Half swap of ra at each lane width, indexed by width code
	logic [3:0][0:WORD_W-1] rot;

	for (genvar w = 0; w < 4; w++) begin : g_width
		localparam int LW = LANE_W8 << w;

		for (genvar i = 0; i < WORD_W / LW; i++) begin : g_lane
			assign rot[w][i*LW +: LW] = {ra[i*LW + LW/2 +: LW/2], ra[i*LW +: LW/2]};
		end
	end

	always_comb begin
		case (logic_op)
			LOP_AND:  result = ra & rb;
			LOP_OR:   result = ra | rb;
			LOP_XOR:  result = ra ^ rb;
			LOP_NOT:  result = ~ra;
			LOP_MOV:  result = ra;
			LOP_RTTH: result = rot[ww];
			default:  result = '0;
		endcase
	end

endmodule

// ==== source/simd_mult.sv ====
`timescale 1ns/1ps

module simd_mult
	import simd_data_pkg::*;
#(
	parameter int LANE_W = LANE_W8
) (
	input  word_t ra,
	input  word_t rb,
	input  logic  mult_odd,
	input  logic  mult_square,
	output word_t product
);

	localparam int PAIRS = WORD_W / (2 * LANE_W);

	if (LANE_W > MULT_MAX_W) begin : g_width_check
		$error("simd_mult lane width %0d exceeds %0d", LANE_W, MULT_MAX_W);
	end

	for (genvar p = 0; p < PAIRS; p++) begin : g_pair
		localparam int EVEN_LSB = 2 * p * LANE_W;
		localparam int ODD_LSB  = (2 * p + 1) * LANE_W;

		logic [LANE_W-1:0]   a;
		logic [LANE_W-1:0]   b;
		logic [2*LANE_W-1:0] prod;

		assign a = mult_odd ? ra[ODD_LSB +: LANE_W] : ra[EVEN_LSB +: LANE_W];
		// Square reuses the ra lane as second factor
		assign b = mult_square ? a :
			(mult_odd ? rb[ODD_LSB +: LANE_W] : rb[EVEN_LSB +: LANE_W]);

		assign prod = a * b;

		// Product takes the place of both lanes of the pair
		assign product[EVEN_LSB +: 2*LANE_W] = prod;
	end

endmodule

// ==== source/vector_alu.sv ====
`timescale 1ns/1ps

module vector_alu
	import simd_data_pkg::*;
	import alu_op_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  word_t  ra,
	input  word_t  rb,
	input  r_ins_e r_ins,
	input  width_e ww,
	input  logic   op_en,
	output word_t  alu_out
);

	unit_e     unit_sel;
	logic_op_e logic_op;
	arith_op_e arith_op;
	logic      mult_odd;
	logic      mult_square;
	word_t     logic_word;
	word_t     arith_w8;
	word_t     arith_w16;
	word_t     arith_w32;
	word_t     arith_w64;
	word_t     mult_w8;
	word_t     mult_w16;
	word_t     mult_w32;

	alu_op_decode u_decode (
		.r_ins(r_ins), .ww(ww), .op_en(op_en),
		.unit_sel(unit_sel), .logic_op(logic_op), .arith_op(arith_op),
		.mult_odd(mult_odd), .mult_square(mult_square)
	);

	simd_addsub_shift #(.LANE_W(LANE_W8)) u_arith_w8 (
		.ra(ra), .rb(rb), .arith_op(arith_op), .result(arith_w8)
	);
	simd_addsub_shift #(.LANE_W(LANE_W16)) u_arith_w16 (
		.ra(ra), .rb(rb), .arith_op(arith_op), .result(arith_w16)
	);
	simd_addsub_shift #(.LANE_W(LANE_W32)) u_arith_w32 (
		.ra(ra), .rb(rb), .arith_op(arith_op), .result(arith_w32)
	);
	simd_addsub_shift #(.LANE_W(LANE_W64)) u_arith_w64 (
		.ra(ra), .rb(rb), .arith_op(arith_op), .result(arith_w64)
	);

	simd_mult #(.LANE_W(LANE_W8)) u_mult_w8 (
		.ra(ra), .rb(rb), .mult_odd(mult_odd), .mult_square(mult_square), .product(mult_w8)
	);
	simd_mult #(.LANE_W(LANE_W16)) u_mult_w16 (
		.ra(ra), .rb(rb), .mult_odd(mult_odd), .mult_square(mult_square), .product(mult_w16)
	);
	simd_mult #(.LANE_W(LANE_W32)) u_mult_w32 (
		.ra(ra), .rb(rb), .mult_odd(mult_odd), .mult_square(mult_square), .product(mult_w32)
	);

	simd_logic_rotate u_logic (
		.ra(ra), .rb(rb), .logic_op(logic_op), .ww(ww), .result(logic_word)
	);

	alu_result_stage u_result (
		.clk(clk), .reset(reset), .unit_sel(unit_sel), .ww(ww),
		.logic_word(logic_word),
		.arith_w8(arith_w8), .arith_w16(arith_w16),
		.arith_w32(arith_w32), .arith_w64(arith_w64),
		.mult_w8(mult_w8), .mult_w16(mult_w16), .mult_w32(mult_w32),
		.alu_out(alu_out)
	);

endmodule

// ==== tests/vector_alu_model.svh ====
`ifndef VECTOR_ALU_MODEL_SVH
`define VECTOR_ALU_MODEL_SVH

// Expected results on a plain [63:0] view, so lane 0 sits at the top bits

// Add, subtract, shifts and half swap, one lane of width lw at a time
function automatic logic [63:0] lane_model(input logic [63:0] a, input logic [63:0] b,
		input r_ins_e op, input int lw);
	logic [63:0] mask;
	logic [63:0] x;
	logic [63:0] y;
	logic [63:0] z;
	logic [63:0] res;
	logic neg;
	int sh;
	mask = (lw == 64) ? {64{1'b1}} : ((64'd1 << lw) - 64'd1);
	res = '0;
	for (int pos = 0; pos < 64; pos += lw) begin
		x = (a >> pos) & mask;
		y = (b >> pos) & mask;
		// Amount is the low log2(lw) bits of the rb lane
		sh = int'(y & 64'(lw - 1));
		neg = ((x >> (lw - 1)) & 64'd1) != 64'd0;
		case (op)
			VADD: z = x + y;
			VSUB: z = x - y;
			VSLL: z = x << sh;
			VSRL: z = x >> sh;
			VSRA: z = (x >> sh) | (neg ? (mask & ~(mask >> sh)) : 64'd0);
			VRTTH: z = (x >> (lw / 2)) | (x << (lw / 2));
			default: z = '0;
		endcase
		res = res | ((z & mask) << pos);
	end
	return res;
endfunction

// Even lane is the upper half of each pair, odd lane the lower half
function automatic logic [63:0] mult_model(input logic [63:0] a, input logic [63:0] b,
		input logic odd, input logic square, input int lw);
	logic [63:0] mask;
	logic [63:0] fa;
	logic [63:0] fb;
	logic [63:0] res;
	int sel;
	mask = (64'd1 << lw) - 64'd1;
	res = '0;
	for (int pos = 0; pos < 64; pos += 2 * lw) begin
		sel = odd ? pos : pos + lw;
		fa = (a >> sel) & mask;
		fb = square ? fa : ((b >> sel) & mask);
		res = res | ((fa * fb) << pos);
	end
	return res;
endfunction

function automatic logic [63:0] expected_out(input logic [63:0] a, input logic [63:0] b,
		input r_ins_e op, input width_e w, input logic en);
	logic [63:0] res;
	int lw;
	lw = 8 << int'(w);
	res = '0;
	if (en) begin
		case (op)
			VAND: res = a & b;
			VOR: res = a | b;
			VXOR: res = a ^ b;
			VNOT: res = ~a;
			VMOV: res = a;
			VADD, VSUB, VSLL, VSRL, VSRA, VRTTH: res = lane_model(a, b, op, lw);
			VMULEU, VMULOU, VSQEU, VSQOU: begin
				// No multiply at 64-bit lanes
				if (w != WIDTH_64) begin
					res = mult_model(a, b, op == VMULOU || op == VSQOU,
						op == VSQEU || op == VSQOU, lw);
				end
			end
			default: res = '0;
		endcase
	end
	return res;
endfunction

`endif

// ==== tests/vector_alu_tb.sv ====
`timescale 1ns/1ps

module vector_alu_tb
	import simd_data_pkg::*;
	import alu_op_pkg::*;
();

	localparam int RESET_CYCLES = 10;
	localparam int PHASES = 6;
	localparam int PHASE_CYCLES = 200;
	// Whole run plus some margin
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + PHASES * PHASE_CYCLES + 190;

	logic clk;
	logic reset;
	word_t ra;
	word_t rb;
	r_ins_e r_ins;
	width_e ww;
	logic op_en;
	word_t alu_out;

	integer seed;
	int cycle_count = 0;

	logic [63:0] model_out;
	logic sel_logic;
	logic sel_addsub;
	logic sel_shift;
	logic sel_mult;
	logic sel_zero;

	`include "vector_alu_model.svh"

	vector_alu u_dut (
		.clk(clk),
		.reset(reset),
		.ra(ra),
		.rb(rb),
		.r_ins(r_ins),
		.ww(ww),
		.op_en(op_en),
		.alu_out(alu_out)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	assign model_out = expected_out(ra, rb, r_ins, ww, op_en);
	assign sel_logic = op_en && (r_ins inside {VAND, VOR, VXOR, VNOT, VMOV, VRTTH});
	assign sel_addsub = op_en && (r_ins inside {VADD, VSUB});
	assign sel_shift = op_en && (r_ins inside {VSLL, VSRL, VSRA});
	assign sel_mult = op_en && (r_ins inside {VMULEU, VMULOU, VSQEU, VSQOU});
	assign sel_zero = !op_en || (r_ins inside {VNOP, VDIV, VMOD, VSQRT});

	task automatic report_failure(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	a_reset_zero: assert property (@(posedge clk) $past(reset) |-> alu_out == '0)
		else report_failure("alu_out not zero during or right after reset");

	a_logic: assert property (@(posedge clk)
		!reset && !$past(reset) && $past(sel_logic) |-> alu_out == $past(model_out))
		else report_failure("bitwise or RTTH result differs from model");

	a_addsub: assert property (@(posedge clk)
		!reset && !$past(reset) && $past(sel_addsub) |-> alu_out == $past(model_out))
		else report_failure("ADD or SUB lane result differs from model");

	a_shift: assert property (@(posedge clk)
		!reset && !$past(reset) && $past(sel_shift) |-> alu_out == $past(model_out))
		else report_failure("shift lane result differs from model");

	a_mult: assert property (@(posedge clk)
		!reset && !$past(reset) && $past(sel_mult) |-> alu_out == $past(model_out))
		else report_failure("multiply or square product differs from model");

	a_zero: assert property (@(posedge clk)
		!reset && !$past(reset) && $past(sel_zero) |-> alu_out == '0)
		else report_failure("disabled or unsupported operation gave nonzero result");

	function automatic r_ins_e phase_code(input int phase, input int k);
		r_ins_e code;
		case (phase)
			0: code = (k % 6 == 5) ? VRTTH : r_ins_e'(6'(1 + k % 6));
			1: code = r_ins_e'(6'(6 + k % 2));
			2: code = r_ins_e'(6'(10 + k % 3));
			3: code = r_ins_e'(6'(8 + k % 2));
			4: code = r_ins_e'(6'(16 + k % 2));
			default: begin
				case (k % 4)
					0: code = VNOP;
					1: code = VDIV;
					2: code = VMOD;
					default: code = VSQRT;
				endcase
			end
		endcase
		return code;
	endfunction

	// Width steps every 6 cycles so each code meets all four widths
	task automatic apply_op(input int phase, input int k);
		ra = {$random(seed), $random(seed)};
		rb = {$random(seed), $random(seed)};
		ww = width_e'(2'((k / 6) % 4));
		op_en = 1'b1;
		r_ins = phase_code(phase, k);
		// Last phase also runs any code with op_en low
		if (phase == PHASES - 1 && (k / 8) % 2 == 1) begin
			op_en = 1'b0;
			r_ins = r_ins_e'(6'(k % 19));
		end
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run went past %0d clock cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		seed = 32'he4b2_a1e4;
		reset = 1'b1;
		ra = '0;
		rb = '0;
		r_ins = VNOP;
		ww = WIDTH_8;
		op_en = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		reset = 1'b0;
		for (int phase = 0; phase < PHASES; phase++) begin
			for (int k = 0; k < PHASE_CYCLES; k++) begin
				apply_op(phase, k);
				@(posedge clk);
				#2;
			end
		end
		// Let the last result reach the checks
		repeat (2) @(posedge clk);
		#2;
		$display("Test completed successfully");
		$finish;
	end

endmodule
